/* Makefile */
LOG := sim.log

.PHONY: all compile run clean

all: run

compile: obj_dir/Vlsu_tb

obj_dir/Vlsu_tb: flist.f $(wildcard hw/*.sv) $(wildcard test/*.sv)
	verilator --binary --timing --assert --top-module lsu_tb -f flist.f -o Vlsu_tb

run: obj_dir/Vlsu_tb
	./obj_dir/Vlsu_tb | tee $(LOG)
	grep -q '^>>> PASS$$' $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* flist.f */
hw/lsu_pkg.sv
hw/axi_lite_pkg.sv
hw/lsu_access_plan.sv
hw/lsu_load_merge.sv
hw/lsu_ctrl.sv
hw/lsu_top.sv
test/lsu_assertions.sv
test/lsu_tb.sv

/* hw/axi_lite_pkg.sv */
`default_nettype none

package axi_lite_pkg;

	// B and R channel response
	typedef logic [1:0] resp_t;

	localparam resp_t RESP_OKAY   = 2'b00;
	// 2'b01 is EXOKAY, which AXI4-Lite does not use
	localparam resp_t RESP_SLVERR = 2'b10;
	localparam resp_t RESP_DECERR = 2'b11;

endpackage

`default_nettype wire

/* hw/lsu_access_plan.sv */
`default_nettype none

module lsu_access_plan
	import lsu_pkg::*;
(
	input  wire          clock,
	input  wire          reset,
	input  wire          accept,
	input  wire          second_part,
	input  wire mem_op_t req_op,
	input  wire addr_t   req_addr,
	input  wire word_t   req_wdata,
	output logic         is_load,
	output logic         is_store,
	output logic         need_second,
	output addr_t        part_addr,
	output strb_t        part_strb,
	output strb_t        first_strb,
	output lane_t        lane_offset,
	output mem_op_t      op,
	output beat_t        beat_wdata
);

	mem_op_t      op_q;
	addr_t        addr_q;
	word_t        wdata_q;
	logic         load_q;
	logic         store_q;

	lane_t        offset;
	logic [3:0]   byte_mask;
	logic [15:0]  lane_span;
	strb_t        access_strb;
	strb_t        half_mask;
	strb_t        second_strb;
	addr_t        next_addr;
	logic [127:0] wide_wdata;

	// ----------------------------------------------------------------------
	// request register
	// ----------------------------------------------------------------------
	always_ff @(posedge clock) begin
		if (reset) begin
			load_q  <= 1'b0;
			store_q <= 1'b0;
		end else if (accept) begin
			load_q  <= op_is_load(req_op);
			store_q <= op_is_store(req_op);
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			op_q    <= req_op;
			addr_q  <= req_addr;
			wdata_q <= req_wdata;
		end
	end

	// ----------------------------------------------------------------------
	// lanes and split decision
	// ----------------------------------------------------------------------
	assign offset    = addr_q[2:0];
	assign byte_mask = op_byte_mask(op_q);

	// lanes before wrapping past lane 7
	assign lane_span   = {12'b0, byte_mask} << offset;
	assign access_strb = lane_span[7:0] | lane_span[15:8];

	// 4-byte half of the beat holding the first byte
	assign half_mask   = offset[2] ? 8'hf0 : 8'h0f;
	assign first_strb  = access_strb & half_mask;
	// whatever spills out of that half goes in a second part
	assign second_strb = access_strb & ~half_mask;
	assign need_second = |second_strb;

	assign next_addr = {addr_q[31:2], 2'b00} + 32'd4;
	assign part_addr = second_part ? next_addr : addr_q;
	assign part_strb = second_part ? second_strb : first_strb;

	// byte k of the store data lands on lane (o+k) mod 8
	assign wide_wdata = {96'b0, wdata_q} << {offset, 3'b000};
	assign beat_wdata = wide_wdata[63:0] | wide_wdata[127:64];

	assign is_load     = load_q;
	assign is_store    = store_q;
	assign lane_offset = offset;
	assign op          = op_q;

endmodule

`default_nettype wire

/* hw/lsu_ctrl.sv */
`default_nettype none

module lsu_ctrl
	import lsu_pkg::*;
	import axi_lite_pkg::*;
(
	input  wire        clock,
	input  wire        reset,
	input  wire        req_valid,
	input  wire        is_load,
	input  wire        is_store,
	input  wire        need_second,
	input  wire word_t load_word,
	input  wire        awready,
	input  wire        wready,
	input  wire resp_t bresp,
	input  wire        bvalid,
	input  wire        arready,
	input  wire resp_t rresp,
	input  wire        rvalid,
	output logic       req_ready,
	output logic       accept,
	output logic       second_part,
	output logic       beat_take,
	output logic       rsp_valid,
	output word_t      rsp_rdata,
	output logic       rsp_err,
	output logic       awvalid,
	output logic       wvalid,
	output logic       bready,
	output logic       arvalid,
	output logic       rready
);

	typedef enum logic [2:0] {
		IDLE,
		ISSUE,
		WAIT_ADDR_DATA,
		WAIT_RESP,
		DONE
	} state_t;

	state_t state;
	state_t state_next;
	logic   aw_done;
	logic   w_done;
	logic   second_q;
	logic   err_q;

	logic   aw_fire;
	logic   w_fire;
	logic   ar_fire;
	logic   b_fire;
	logic   r_fire;
	logic   resp_fire;
	logic   resp_bad;
	logic   addr_data_done;
	logic   last_part;

	// ----------------------------------------------------------------------
	// handshakes
	// ----------------------------------------------------------------------
	assign req_ready = (state == IDLE);
	assign accept    = req_valid && req_ready;

	// AW and W go up together, each drops on its own handshake
	assign awvalid = (state == WAIT_ADDR_DATA) && is_store && !aw_done;
	assign wvalid  = (state == WAIT_ADDR_DATA) && is_store && !w_done;
	assign arvalid = (state == WAIT_ADDR_DATA) && is_load;
	assign bready  = (state == WAIT_RESP) && is_store;
	assign rready  = (state == WAIT_RESP) && is_load;

	assign aw_fire = awvalid && awready;
	assign w_fire  = wvalid && wready;
	assign ar_fire = arvalid && arready;
	assign b_fire  = bvalid && bready;
	assign r_fire  = rvalid && rready;

	assign addr_data_done = is_store ? ((aw_done || aw_fire) && (w_done || w_fire)) : ar_fire;
	assign resp_fire      = b_fire || r_fire;
	assign resp_bad       = (b_fire && bresp != RESP_OKAY) || (r_fire && rresp != RESP_OKAY);
	assign last_part      = !need_second || second_q;

	assign beat_take   = r_fire;
	assign second_part = second_q;
	assign rsp_valid   = (state == DONE);

	// ----------------------------------------------------------------------
	// state machine
	// ----------------------------------------------------------------------
	always_comb begin
		state_next = state;
		case (state)
			IDLE: begin
				if (accept) begin
					state_next = ISSUE;
				end
			end
			ISSUE: state_next = WAIT_ADDR_DATA;
			WAIT_ADDR_DATA: begin
				if (addr_data_done) begin
					state_next = WAIT_RESP;
				end
			end
			WAIT_RESP: begin
				if (resp_fire) begin
					state_next = last_part ? DONE : ISSUE;
				end
			end
			DONE: state_next = IDLE;
			default: state_next = IDLE;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= IDLE;
		end else begin
			state <= state_next;
		end
	end

	// per-part channel flags, part select and sticky error
	always_ff @(posedge clock) begin
		if (reset) begin
			aw_done  <= 1'b0;
			w_done   <= 1'b0;
			second_q <= 1'b0;
			err_q    <= 1'b0;
		end else begin
			if (accept) begin
				second_q <= 1'b0;
				err_q    <= 1'b0;
			end
			if (state == ISSUE) begin
				aw_done <= 1'b0;
				w_done  <= 1'b0;
			end
			if (aw_fire) begin
				aw_done <= 1'b1;
			end
			if (w_fire) begin
				w_done <= 1'b1;
			end
			if (resp_fire && resp_bad) begin
				err_q <= 1'b1;
			end
			if (resp_fire && !last_part) begin
				second_q <= 1'b1;
			end
		end
	end

	// response captured on the final B or R handshake
	always_ff @(posedge clock) begin
		if (reset) begin
			rsp_err <= 1'b0;
		end else if (resp_fire && last_part) begin
			rsp_err <= err_q || resp_bad;
		end
	end

	always_ff @(posedge clock) begin
		if (resp_fire && last_part) begin
			rsp_rdata <= is_load ? load_word : '0;
		end
	end

endmodule

`default_nettype wire

/* hw/lsu_load_merge.sv */
`default_nettype none

module lsu_load_merge
	import lsu_pkg::*;
(
	input  wire          clock,
	input  wire          reset,
	input  wire          beat_take,
	input  wire          second_part,
	input  wire          need_second,
	input  wire beat_t   rdata,
	input  wire strb_t   first_strb,
	input  wire lane_t   lane_offset,
	input  wire mem_op_t op,
	output word_t        load_word
);

	beat_t held_beat;
	logic  held_valid;
	beat_t merged;
	word_t gathered;

	// first beat of a split load
	always_ff @(posedge clock) begin
		if (beat_take && need_second && !second_part) begin
			held_beat <= rdata;
		end
	end

	// set by the first beat, dropped again by the second
	always_ff @(posedge clock) begin
		if (reset) begin
			held_valid <= 1'b0;
		end else if (beat_take) begin
			held_valid <= need_second && !second_part;
		end
	end

	always_comb begin : gather
		lane_t lane;

		merged = rdata;
		// lanes of the first part come from the held beat
		for (int l = 0; l < 8; l++) begin
			if (held_valid && first_strb[l]) begin
				merged[8*l +: 8] = held_beat[8*l +: 8];
			end
		end
		for (int k = 0; k < 4; k++) begin
			lane = lane_offset + lane_t'(k);
			gathered[8*k +: 8] = merged[8*lane +: 8];
		end
	end

	// sign or zero extension
	always_comb begin
		case (op)
			OP_LB:   load_word = {{24{gathered[7]}}, gathered[7:0]};
			OP_LBU:  load_word = {24'b0, gathered[7:0]};
			OP_LH:   load_word = {{16{gathered[15]}}, gathered[15:0]};
			OP_LHU:  load_word = {16'b0, gathered[15:0]};
			OP_LW:   load_word = gathered;
			default: load_word = '0;
		endcase
	end

endmodule

`default_nettype wire

/* hw/lsu_pkg.sv */
`default_nettype none

package lsu_pkg;

	// ----------------------------------------------------------------------
	// widths of the load/store datapath
	// ----------------------------------------------------------------------
	typedef logic [31:0] addr_t;
	typedef logic [31:0] word_t;
	typedef logic [63:0] beat_t;
	typedef logic [7:0]  strb_t;
	typedef logic [2:0]  lane_t;

	// the eight RISC-V access kinds
	typedef enum logic [3:0] {
		OP_LB,
		OP_LBU,
		OP_LH,
		OP_LHU,
		OP_LW,
		OP_SB,
		OP_SH,
		OP_SW
	} mem_op_t;

	function automatic logic op_is_load(input mem_op_t kind);
		return kind inside {OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW};
	endfunction

	function automatic logic op_is_store(input mem_op_t kind);
		return kind inside {OP_SB, OP_SH, OP_SW};
	endfunction

	// bytes touched, counted from byte 0 of the access
	function automatic logic [3:0] op_byte_mask(input mem_op_t kind);
		case (kind)
			OP_LB, OP_LBU, OP_SB: return 4'b0001;
			OP_LH, OP_LHU, OP_SH: return 4'b0011;
			default:              return 4'b1111;
		endcase
	endfunction

endpackage

`default_nettype wire

/* hw/lsu_top.sv */
`default_nettype none

module lsu_top
	import lsu_pkg::*;
	import axi_lite_pkg::*;
(
	input  wire          clock,
	input  wire          reset,
	// upstream request
	input  wire          req_valid,
	input  wire mem_op_t req_op,
	input  wire addr_t   req_addr,
	input  wire word_t   req_wdata,
	output wire          req_ready,
	// response
	output wire          rsp_valid,
	output wire word_t   rsp_rdata,
	output wire          rsp_err,
	// AXI4-Lite master
	output wire addr_t   awaddr,
	output wire          awvalid,
	input  wire          awready,
	output wire beat_t   wdata,
	output wire strb_t   wstrb,
	output wire          wvalid,
	input  wire          wready,
	input  wire resp_t   bresp,
	input  wire          bvalid,
	output wire          bready,
	output wire addr_t   araddr,
	output wire          arvalid,
	input  wire          arready,
	input  wire beat_t   rdata,
	input  wire resp_t   rresp,
	input  wire          rvalid,
	output wire          rready
);

	logic    accept;
	logic    second_part;
	logic    beat_take;
	logic    is_load;
	logic    is_store;
	logic    need_second;
	addr_t   part_addr;
	strb_t   part_strb;
	strb_t   first_strb;
	lane_t   lane_offset;
	mem_op_t op;
	word_t   load_word;

	lsu_ctrl u_lsu_ctrl (
		.clock       (clock),
		.reset       (reset),
		.req_valid   (req_valid),
		.is_load     (is_load),
		.is_store    (is_store),
		.need_second (need_second),
		.load_word   (load_word),
		.awready     (awready),
		.wready      (wready),
		.bresp       (bresp),
		.bvalid      (bvalid),
		.arready     (arready),
		.rresp       (rresp),
		.rvalid      (rvalid),
		.req_ready   (req_ready),
		.accept      (accept),
		.second_part (second_part),
		.beat_take   (beat_take),
		.rsp_valid   (rsp_valid),
		.rsp_rdata   (rsp_rdata),
		.rsp_err     (rsp_err),
		.awvalid     (awvalid),
		.wvalid      (wvalid),
		.bready      (bready),
		.arvalid     (arvalid),
		.rready      (rready)
	);

	lsu_access_plan u_lsu_access_plan (
		.clock       (clock),
		.reset       (reset),
		.accept      (accept),
		.second_part (second_part),
		.req_op      (req_op),
		.req_addr    (req_addr),
		.req_wdata   (req_wdata),
		.is_load     (is_load),
		.is_store    (is_store),
		.need_second (need_second),
		.part_addr   (part_addr),
		.part_strb   (part_strb),
		.first_strb  (first_strb),
		.lane_offset (lane_offset),
		.op          (op),
		.beat_wdata  (wdata)
	);

	lsu_load_merge u_lsu_load_merge (
		.clock       (clock),
		.reset       (reset),
		.beat_take   (beat_take),
		.second_part (second_part),
		.need_second (need_second),
		.rdata       (rdata),
		.first_strb  (first_strb),
		.lane_offset (lane_offset),
		.op          (op),
		.load_word   (load_word)
	);

	// one address per part, shared by both channels
	assign awaddr = part_addr;
	assign araddr = part_addr;
	assign wstrb  = part_strb;

endmodule

`default_nettype wire

/* test/lsu_assertions.sv */
`default_nettype none

module lsu_assertions
	import lsu_pkg::*;
(
	input wire        clock,
	input wire        reset,
	input wire        req_ready,
	input wire        rsp_valid,
	input wire addr_t awaddr,
	input wire        awvalid,
	input wire        awready,
	input wire beat_t wdata,
	input wire strb_t wstrb,
	input wire        wvalid,
	input wire        wready,
	input wire        bvalid,
	input wire        bready,
	input wire addr_t araddr,
	input wire        arvalid,
	input wire        arready,
	input wire        rvalid,
	input wire        rready
);

	logic aw_open;
	logic ar_open;

	// address accepted, response not yet taken
	always_ff @(posedge clock) begin
		if (reset) begin
			aw_open <= 1'b0;
			ar_open <= 1'b0;
		end else begin
			if (awvalid && awready) begin
				aw_open <= 1'b1;
			end else if (bvalid && bready) begin
				aw_open <= 1'b0;
			end
			if (arvalid && arready) begin
				ar_open <= 1'b1;
			end else if (rvalid && rready) begin
				ar_open <= 1'b0;
			end
		end
	end

	// ----------------------------------------------------------------------
	// valid held with stable payload until ready
	// ----------------------------------------------------------------------
	aw_hold: assert property (@(posedge clock) disable iff (reset)
		awvalid && !awready |=> awvalid && $stable(awaddr))
		else $error("awvalid dropped or awaddr changed before awready");

	w_hold: assert property (@(posedge clock) disable iff (reset)
		wvalid && !wready |=> wvalid && $stable(wdata) && $stable(wstrb))
		else $error("wvalid dropped or write data changed before wready");

	ar_hold: assert property (@(posedge clock) disable iff (reset)
		arvalid && !arready |=> arvalid && $stable(araddr))
		else $error("arvalid dropped or araddr changed before arready");

	// response ready only after its address handshake
	bready_after_aw: assert property (@(posedge clock) disable iff (reset)
		bready |-> aw_open)
		else $error("bready raised without an accepted write address");

	rready_after_ar: assert property (@(posedge clock) disable iff (reset)
		rready |-> ar_open)
		else $error("rready raised without an accepted read address");

	reset_outputs: assert property (@(posedge clock)
		reset |=> !awvalid && !wvalid && !bready && !arvalid && !rready
			&& !rsp_valid && req_ready)
		else $error("control outputs not in their idle state after reset");

endmodule

`default_nettype wire

/* test/lsu_tb.sv */
`default_nettype none

module lsu_tb
	import lsu_pkg::*;
	import axi_lite_pkg::*;
();

	localparam int    TIMEOUT  = 500;
	localparam addr_t ERR_WORD = 32'h0000_00c0;

	logic    clock = 1'b0;
	logic    reset;
	logic    req_valid;
	mem_op_t req_op;
	addr_t   req_addr;
	word_t   req_wdata;
	logic    req_ready;
	logic    rsp_valid;
	word_t   rsp_rdata;
	logic    rsp_err;
	addr_t   awaddr;
	logic    awvalid;
	beat_t   wdata;
	strb_t   wstrb;
	logic    wvalid;
	logic    bready;
	addr_t   araddr;
	logic    arvalid;
	logic    rready;

	// memory model outputs
	logic    awready = 1'b0;
	logic    wready = 1'b0;
	logic    arready = 1'b0;
	logic    bvalid = 1'b0;
	resp_t   bresp = RESP_OKAY;
	logic    rvalid = 1'b0;
	resp_t   rresp = RESP_OKAY;
	beat_t   rdata = '0;

	logic [7:0] mem [0:255];
	logic [7:0] ref_mem [0:255];
	addr_t   aw_log [$];
	strb_t   w_log [$];
	addr_t   ar_log [$];
	logic    aw_have = 1'b0;
	logic    w_have = 1'b0;
	logic    b_pend = 1'b0;
	logic    b_err = 1'b0;
	logic    r_pend = 1'b0;
	addr_t   aw_q = '0;
	addr_t   ar_q = '0;
	beat_t   w_q = '0;
	strb_t   ws_q = '0;
	int      b_wait = 0;
	int      r_wait = 0;
	logic    delays;
	logic    hung;
	int      errors;
	int      checks;

	always #4 clock = ~clock;

	lsu_top u_lsu_top (.*);

	bind lsu_top lsu_assertions u_lsu_assertions (.*);

	function automatic logic [7:0] fill_byte(input int i);
		logic [7:0] b;
		b = 8'(i);
		return {b[2:0], b[7:3]} ^ 8'ha7;
	endfunction

	// ----------------------------------------------------------------------
	// AXI4-Lite memory model sampled on the rising edge
	// ----------------------------------------------------------------------
	always @(posedge clock) begin : slave_edge
		logic [7:0] base;
		if (reset) begin
			aw_have = 1'b0;
			w_have = 1'b0;
			b_pend = 1'b0;
			r_pend = 1'b0;
			for (int i = 0; i < 256; i++) begin
				mem[i] = fill_byte(i);
			end
		end else begin
			if (awvalid && awready) begin
				aw_have = 1'b1;
				aw_q = awaddr;
				aw_log.push_back(awaddr);
			end
			if (wvalid && wready) begin
				w_have = 1'b1;
				w_q = wdata;
				ws_q = wstrb;
				w_log.push_back(wstrb);
			end
			if (bvalid && bready) begin
				b_pend = 1'b0;
			end else if (b_pend && b_wait > 0) begin
				b_wait--;
			end
			// apply strobes once address and data are both in
			if (aw_have && w_have) begin
				base = {aw_q[7:3], 3'b000};
				for (int l = 0; l < 8; l++) begin
					if (ws_q[l]) begin
						mem[base + 8'(l)] = w_q[8*l +: 8];
					end
				end
				aw_have = 1'b0;
				w_have = 1'b0;
				b_pend = 1'b1;
				b_err = ({aw_q[31:2], 2'b00} == ERR_WORD);
				b_wait = delays ? int'($urandom % 4) : 0;
			end
			if (rvalid && rready) begin
				r_pend = 1'b0;
			end else if (r_pend && r_wait > 0) begin
				r_wait--;
			end
			if (arvalid && arready) begin
				ar_q = araddr;
				ar_log.push_back(araddr);
				r_pend = 1'b1;
				r_wait = delays ? int'($urandom % 4) : 0;
			end
		end
	end

	// model outputs change on the falling edge
	always @(negedge clock) begin : slave_drive
		awready = delays ? 1'($urandom % 2) : 1'b1;
		wready  = delays ? 1'($urandom % 2) : 1'b1;
		arready = delays ? 1'($urandom % 2) : 1'b1;
		bvalid  = b_pend && b_wait == 0;
		bresp   = b_err ? RESP_SLVERR : RESP_OKAY;
		rvalid  = r_pend && r_wait == 0;
		rresp   = ({ar_q[31:2], 2'b00} == ERR_WORD) ? RESP_SLVERR : RESP_OKAY;
		for (int l = 0; l < 8; l++) begin
			rdata[8*l +: 8] = mem[{ar_q[7:3], 3'(l)}];
		end
	end

	// ----------------------------------------------------------------------
	// reference model
	// ----------------------------------------------------------------------
	function automatic int access_size(input mem_op_t kind);
		case (kind)
			OP_LB, OP_LBU, OP_SB: return 1;
			OP_LH, OP_LHU, OP_SH: return 2;
			default:              return 4;
		endcase
	endfunction

	function automatic logic splits(input mem_op_t kind, input addr_t addr);
		lane_t o;
		o = addr[2:0];
		case (access_size(kind))
			4:       return !(o == 3'd0 || o == 3'd4);
			2:       return o == 3'd3 || o == 3'd7;
			default: return 1'b0;
		endcase
	endfunction

	function automatic addr_t part_address(input addr_t addr, input logic second);
		return second ? {addr[31:2], 2'b00} + 32'd4 : addr;
	endfunction

	// lanes in o's half go first, the rest in the second part
	function automatic strb_t lanes_of(input mem_op_t kind, input addr_t addr, input logic second);
		strb_t s;
		lane_t lane;
		s = '0;
		for (int k = 0; k < access_size(kind); k++) begin
			lane = addr[2:0] + lane_t'(k);
			if ((lane[2] == addr[2]) != second) begin
				s[lane] = 1'b1;
			end
		end
		return s;
	endfunction

	function automatic word_t expected_load(input mem_op_t kind, input addr_t addr);
		word_t raw;
		raw = '0;
		for (int k = 0; k < access_size(kind); k++) begin
			raw[8*k +: 8] = ref_mem[addr[7:0] + 8'(k)];
		end
		case (kind)
			OP_LB:   return {{24{raw[7]}}, raw[7:0]};
			OP_LH:   return {{16{raw[15]}}, raw[15:0]};
			default: return raw;
		endcase
	endfunction

	function automatic logic expected_err(input mem_op_t kind, input addr_t addr);
		addr_t first_word;
		first_word = {addr[31:2], 2'b00};
		return first_word == ERR_WORD || (splits(kind, addr) && first_word + 32'd4 == ERR_WORD);
	endfunction

	// ----------------------------------------------------------------------
	// checks and run control
	// ----------------------------------------------------------------------
	task automatic check_value(input string name, input logic [63:0] actual,
			input logic [63:0] expected);
		checks++;
		assert (actual === expected) else begin
			errors++;
			$display("CHECK FAILED at %0t: %s expected %h got %h", $time, name, expected, actual);
		end
	endtask

	task automatic check_true(input logic cond, input string what);
		checks++;
		assert (cond) else begin
			errors++;
			$display("at %0t: %s", $time, what);
		end
	endtask

	task automatic finish_run();
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	endtask

	// a stuck DUT ends all further accesses
	task automatic timed_out(input string what);
		$display("timeout at %0t: %s", $time, what);
		errors++;
		hung = 1'b1;
	endtask

	task automatic compare_memory();
		for (int i = 0; i < 256; i++) begin
			check_value($sformatf("mem[%02h]", i), 64'(mem[i]), 64'(ref_mem[i]));
		end
	endtask

	// one request through to its response and its checks against the model
	task automatic access(input mem_op_t kind, input addr_t addr, input word_t data);
		int    aw_start;
		int    w_start;
		int    ar_start;
		int    n_parts;
		int    wait_cycles;
		logic  store;
		word_t exp_rdata;
		word_t got_rdata;
		logic  got_err;
		if (hung) begin
			return;
		end
		store = kind inside {OP_SB, OP_SH, OP_SW};
		n_parts = splits(kind, addr) ? 2 : 1;
		aw_start = aw_log.size();
		w_start = w_log.size();
		ar_start = ar_log.size();
		exp_rdata = store ? '0 : expected_load(kind, addr);
		@(negedge clock);
		req_valid = 1'b1;
		req_op = kind;
		req_addr = addr;
		req_wdata = data;
		wait_cycles = 0;
		while (!req_ready && !hung) begin
			@(negedge clock);
			wait_cycles++;
			if (wait_cycles > TIMEOUT) timed_out("request was never accepted");
		end
		if (hung) begin
			return;
		end
		@(negedge clock);
		req_valid = 1'b0;
		wait_cycles = 0;
		while (!rsp_valid && !hung) begin
			check_true(!req_ready, "req_ready high while an access is in flight");
			@(negedge clock);
			wait_cycles++;
			if (wait_cycles > TIMEOUT) timed_out("no response to the request");
		end
		if (hung) begin
			return;
		end
		got_rdata = rsp_rdata;
		got_err = rsp_err;
		check_true(!req_ready, "req_ready high in the response cycle");
		check_value("rsp_rdata", 64'(got_rdata), 64'(exp_rdata));
		check_value("rsp_err", 64'(got_err), 64'(expected_err(kind, addr)));
		if (store) begin
			check_value("aw handshakes", 64'(aw_log.size() - aw_start), 64'(n_parts));
			check_value("w handshakes", 64'(w_log.size() - w_start), 64'(n_parts));
			check_value("ar handshakes", 64'(ar_log.size() - ar_start), 64'(0));
			for (int p = 0; p < n_parts && aw_start + p < aw_log.size(); p++) begin
				check_value("awaddr", 64'(aw_log[aw_start + p]), 64'(part_address(addr, p != 0)));
			end
			for (int p = 0; p < n_parts && w_start + p < w_log.size(); p++) begin
				check_value("wstrb", 64'(w_log[w_start + p]), 64'(lanes_of(kind, addr, p != 0)));
			end
			for (int k = 0; k < access_size(kind); k++) begin
				ref_mem[addr[7:0] + 8'(k)] = data[8*k +: 8];
			end
			compare_memory();
		end else begin
			check_value("ar handshakes", 64'(ar_log.size() - ar_start), 64'(n_parts));
			check_value("aw handshakes", 64'(aw_log.size() - aw_start), 64'(0));
			for (int p = 0; p < n_parts && ar_start + p < ar_log.size(); p++) begin
				check_value("araddr", 64'(ar_log[ar_start + p]), 64'(part_address(addr, p != 0)));
			end
		end
	endtask

	// ----------------------------------------------------------------------
	// directed tests
	// ----------------------------------------------------------------------
	task automatic reset_state_test();
		check_value("req_ready", 64'(req_ready), 64'(1));
		check_value("awvalid", 64'(awvalid), 64'(0));
		check_value("wvalid", 64'(wvalid), 64'(0));
		check_value("bready", 64'(bready), 64'(0));
		check_value("arvalid", 64'(arvalid), 64'(0));
		check_value("rready", 64'(rready), 64'(0));
		check_value("rsp_valid", 64'(rsp_valid), 64'(0));
	endtask

	task automatic aligned_test();
		access(OP_SW, 32'h10, 32'h1234_5678);
		access(OP_LW, 32'h10, '0);
		access(OP_SH, 32'h22, 32'h0000_4321);
		access(OP_LH, 32'h22, '0);
		access(OP_SB, 32'h35, 32'h0000_0066);
		access(OP_LB, 32'h35, '0);
		access(OP_LW, 32'h14, '0);
	endtask

	task automatic split_test();
		int offsets [6] = '{1, 2, 3, 5, 6, 7};
		addr_t a;
		foreach (offsets[i]) begin
			a = 32'h40 + 32'(8 * i + offsets[i]);
			access(OP_SW, a, 32'hc0de_0000 | 32'(i));
			access(OP_LW, a, '0);
		end
		access(OP_SH, 32'h73, 32'h0000_beef);
		access(OP_LHU, 32'h73, '0);
		access(OP_SH, 32'h7f, 32'h0000_1234);
		access(OP_LH, 32'h7f, '0);
	endtask

	task automatic extension_test();
		access(OP_SB, 32'h90, 32'h0000_0085);
		access(OP_LB, 32'h90, '0);
		access(OP_LBU, 32'h90, '0);
		access(OP_SH, 32'h93, 32'h0000_8001);
		access(OP_LH, 32'h93, '0);
		access(OP_LHU, 32'h93, '0);
		access(OP_SW, 32'h9d, 32'hfedc_ba98);
		access(OP_LB, 32'h9f, '0);
		access(OP_LBU, 32'h9f, '0);
		access(OP_LH, 32'h9f, '0);
		access(OP_LHU, 32'h9f, '0);
	endtask

	// error word hit in the second part, then the first, then a clean access
	task automatic error_test();
		access(OP_SW, 32'hbe, 32'h0bad_f00d);
		access(OP_LW, 32'hc2, '0);
		access(OP_SB, 32'hc1, 32'h0000_0011);
		access(OP_LW, 32'h10, '0);
	endtask

	task automatic backpressure_test();
		mem_op_t kind;
		addr_t   addr;
		word_t   data;
		delays = 1'b1;
		repeat (60) begin
			kind = mem_op_t'($urandom % 8);
			addr = $urandom % 240;
			data = $urandom;
			access(kind, addr, data);
		end
		delays = 1'b0;
	endtask

	initial begin
		void'($urandom(32'hee6e));
		reset = 1'b1;
		req_valid = 1'b0;
		req_op = OP_LW;
		req_addr = '0;
		req_wdata = '0;
		delays = 1'b0;
		hung = 1'b0;
		errors = 0;
		checks = 0;
		for (int i = 0; i < 256; i++) begin
			ref_mem[i] = fill_byte(i);
		end
		repeat (16) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;
		@(negedge clock);
		reset_state_test();
		aligned_test();
		split_test();
		extension_test();
		error_test();
		backpressure_test();
		finish_run();
	end

endmodule

`default_nettype wire
